/* design/afe_pkg.sv */
/*
 * analog front end package
 * sample types, generator input struct and conversion constants
 * shared by the ADC capture and DAC paths
 */

`default_nettype none

package afe_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int unsigned ADC_W = 14;  // converter word, ADC and DAC alike
  localparam int unsigned GEN_W = 14;  // generator and feedback samples
  localparam int unsigned ACQ_DROP = 2;  // low bits dropped on capture
  localparam int unsigned ACQ_W = ADC_W - ACQ_DROP;  // 12 bit acquisition

  ////////////////////
  // sample types
  ////////////////////

  typedef logic [ADC_W-1:0] adc_raw_t;  // raw ADC sample
  typedef logic [ACQ_W-1:0] acq_sample_t;  // upper bits of a raw sample
  typedef logic signed [GEN_W-1:0] gen_sample_t;  // asg or pid sample
  typedef logic [ADC_W-1:0] dac_code_t;  // inverted two's complement
  typedef logic signed [GEN_W:0] sum_t;  // one guard bit for asg + pid

  // one channel's generator inputs
  // asg in the upper half, pid in the lower
  typedef struct packed {
    gen_sample_t asg;  // arbitrary signal generator
    gen_sample_t pid;  // feedback controller
  } gen_pair_t;

  ////////////////////
  // clamp limits
  ////////////////////

  // full signed range of a generator sample
  localparam gen_sample_t SUM_MAX = {1'b0, {(GEN_W-1){1'b1}}};  // +8191
  localparam gen_sample_t SUM_MIN = {1'b1, {(GEN_W-1){1'b0}}};  // -8192

endpackage : afe_pkg

`default_nettype wire

/* design/adc_capture.sv */
/*
 * ADC capture stage
 * registers the raw converter words, crosses the channels and selects
 * between ADC and digital loopback before truncating to 12 bits
 */

`timescale 1ns/1ps
`default_nettype none

module adc_capture
  import afe_pkg::*;
#(
  parameter int unsigned NUM_CH = 2  // converter channels
) (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,  // async, active low
  input  adc_raw_t    [NUM_CH-1:0]    adc_dat_i,  // raw ADC words
  input  dac_code_t   [NUM_CH-1:0]    loop_code_i,  // combinational DAC codes
  input  logic                        digital_loop_i,  // 1 selects loopback
  output acq_sample_t [NUM_CH-1:0]    acq_dat_o  // to acquisition
);

  ////////////////////
  // input register
  ////////////////////

  // stands in for the DDR input stage of the board
  adc_raw_t [NUM_CH-1:0] adc_reg;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_reg <= '0;
    end else begin
      adc_reg <= adc_dat_i;  // one word per clock, no stall
    end
  end

  ////////////////////
  // select register
  ////////////////////

  // acquisition ch k reads ADC ch NUM_CH-1-k
  // loopback takes the DAC code of the same channel
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acq_dat_o <= '0;
    end else begin
      for (int k = 0; k < NUM_CH; k++) begin
        if (digital_loop_i) begin
          // code is already inverted, keep it as is
          acq_dat_o[k] <= loop_code_i[k][ADC_W-1:ACQ_DROP];
        end else begin
          acq_dat_o[k] <= adc_reg[NUM_CH-1-k][ADC_W-1:ACQ_DROP];  // crossed
        end
      end
    end
  end

endmodule : adc_capture

`default_nettype wire

/* design/dac_channel.sv */
/*
 * DAC channel slice
 * adds generator and feedback samples, clamps to the 14 bit signed
 * range and inverts the result into the DAC code
 */

`timescale 1ns/1ps
`default_nettype none

module dac_channel
  import afe_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_n_i,  // async, active low
  input  gen_pair_t gen_i,  // asg and pid of this channel
  output dac_code_t loop_code_o,  // combinational, for loopback
  output dac_code_t code_o  // registered, towards the DAC
);

  sum_t        sum;  // 15 bit, cannot overflow
  gen_sample_t clamped;

  ////////////////////
  // sum and clamp
  ////////////////////

  // both operands signed so the sum sign extends
  assign sum = $signed(gen_i.asg) + $signed(gen_i.pid);

  always_comb begin
    if (sum > SUM_MAX) begin
      clamped = SUM_MAX;  // positive overflow
    end else if (sum < SUM_MIN) begin
      clamped = SUM_MIN;  // negative overflow
    end else begin
      clamped = sum[GEN_W-1:0];  // in range, guard bit dropped
    end
  end

  // DAC coding is the bitwise inverse
  assign loop_code_o = ~clamped;

  ////////////////////
  // code register
  ////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      code_o <= '0;
    end else begin
      code_o <= loop_code_o;  // one cycle from gen_i
    end
  end

endmodule : dac_channel

`default_nettype wire

/* design/dac_output.sv */
/*
 * DAC output stage
 * crosses the channel codes onto the DAC pins and drives the DAC reset
 */

`timescale 1ns/1ps
`default_nettype none

module dac_output
  import afe_pkg::*;
#(
  parameter int unsigned NUM_CH = 2  // converter channels
) (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,  // async, active low
  input  dac_code_t [NUM_CH-1:0]    code_i,  // registered channel codes
  output dac_code_t [NUM_CH-1:0]    dac_dat_o,  // to DAC pins
  output logic                      dac_reset_o  // DAC reset, active high
);

  ////////////////////
  // crossed register
  ////////////////////

  // board wiring swaps channels, DAC k shows slice NUM_CH-1-k
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_o <= '0;
    end else begin
      for (int k = 0; k < NUM_CH; k++) begin
        dac_dat_o[k] <= code_i[NUM_CH-1-k];
      end
    end
  end

  ////////////////////
  // DAC reset
  ////////////////////

  // set at once by reset, released on the first edge after it
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_reset_o <= 1'b1;
    end else begin
      dac_reset_o <= 1'b0;
    end
  end

endmodule : dac_output

`default_nettype wire

/* design/analog_frontend.sv */
/*
 * analog front end top level
 * ADC capture with loopback, per channel DAC slices and DAC output stage
 * of a two channel scope and generator board
 */

`timescale 1ns/1ps
`default_nettype none

module analog_frontend
  import afe_pkg::*;
#(
  parameter int unsigned NUM_CH = 2  // converter channels
) (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,  // async, active low
  // ADC side
  input  adc_raw_t    [NUM_CH-1:0]    adc_dat_i,  // raw converter words
  output acq_sample_t [NUM_CH-1:0]    acq_dat_o,  // to acquisition
  // generator side
  input  gen_pair_t   [NUM_CH-1:0]    gen_i,  // asg and pid per channel
  input  logic                        digital_loop_i,  // loopback enable
  // DAC side
  output dac_code_t   [NUM_CH-1:0]    dac_dat_o,  // to DAC pins
  output logic                        dac_reset_o  // DAC reset
);

  dac_code_t [NUM_CH-1:0] loop_code;  // combinational codes for loopback
  dac_code_t [NUM_CH-1:0] code;  // registered codes for the DAC

  ////////////////////
  // DAC slices
  ////////////////////

  // one identical slice per channel
  for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
    dac_channel i_ch (
      .adc_clk     (adc_clk),
      .rst_n_i     (rst_n_i),
      .gen_i       (gen_i[k]),
      .loop_code_o (loop_code[k]),
      .code_o      (code[k])
    );
  end : g_ch

  ////////////////////
  // ADC capture
  ////////////////////

  // reads the slice codes when loopback is on
  adc_capture #(
    .NUM_CH (NUM_CH)
  ) i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .loop_code_i    (loop_code),
    .digital_loop_i (digital_loop_i),
    .acq_dat_o      (acq_dat_o)  // 2 cycles from adc_dat_i
  );

  ////////////////////
  // DAC output
  ////////////////////

  dac_output #(
    .NUM_CH (NUM_CH)
  ) i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .code_i      (code),
    .dac_dat_o   (dac_dat_o),  // 2 cycles from gen_i
    .dac_reset_o (dac_reset_o)
  );

endmodule : analog_frontend

`default_nettype wire

/* verif/analog_frontend_properties.sv */
/*
 * concurrent checks on the analog front end
 * DAC reset and zero codes during reset, clamped codes on overflow
 */

`timescale 1ns/1ps
`default_nettype none

module analog_frontend_properties
  import afe_pkg::*;
#(
  parameter int unsigned NUM_CH = 2  // converter channels
) (
  input logic                   adc_clk,
  input logic                   rst_n_i,
  input gen_pair_t [NUM_CH-1:0] gen_i,
  input dac_code_t [NUM_CH-1:0] dac_dat_o,
  input logic                   dac_reset_o
);

  function automatic int pair_sum(input gen_pair_t g);
    return int'($signed(g.asg)) + int'($signed(g.pid));
  endfunction

  // DAC held in reset with zero codes
  a_reset_held : assert property (@(posedge adc_clk) !rst_n_i |-> dac_reset_o && dac_dat_o == '0)
    else $error("DAC reset low or DAC data nonzero while rst_n_i is low");

  for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
    // slice k shows on pin NUM_CH-1-k two edges later
    a_clamp_hi : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      pair_sum(gen_i[k]) > int'(SUM_MAX) |-> ##2 dac_dat_o[NUM_CH-1-k] == dac_code_t'(~SUM_MAX))
      else $error("positive overflow of slice %0d not clamped", k);
    a_clamp_lo : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      pair_sum(gen_i[k]) < int'(SUM_MIN) |-> ##2 dac_dat_o[NUM_CH-1-k] == dac_code_t'(~SUM_MIN))
      else $error("negative overflow of slice %0d not clamped", k);
  end : g_ch

endmodule : analog_frontend_properties

bind analog_frontend analog_frontend_properties #(
  .NUM_CH (NUM_CH)
) i_props (
  .adc_clk     (adc_clk),
  .rst_n_i     (rst_n_i),
  .gen_i       (gen_i),
  .dac_dat_o   (dac_dat_o),
  .dac_reset_o (dac_reset_o)
);

`default_nettype wire

/* verif/tb_analog_frontend.sv */
/*
 * testbench for the analog front end
 * LFSR stimulus on generator and ADC inputs, cycle history reference
 * model, per cycle compare of DAC, acquisition and DAC reset outputs
 */

`timescale 1ns/1ps
`default_nettype none

module tb_analog_frontend
  import afe_pkg::*;
#(
  parameter int unsigned NUM_CH = 2  // converter channels
);

  localparam int CLK_PERIOD   = 4;  // ns
  localparam int RST_CYCLES   = 10;
  localparam int NUM_CYCLES   = 600;  // stimulus cycles after reset
  localparam int DRAIN_CYCLES = 4;  // covers the 2 cycle latency
  localparam int WATCHDOG_NS  = (RST_CYCLES + NUM_CYCLES + DRAIN_CYCLES) * CLK_PERIOD + 200;

  // limits of a 14 bit signed sample
  localparam int GEN_HI = (1 << ($bits(gen_sample_t) - 1)) - 1;
  localparam int GEN_LO = -(1 << ($bits(gen_sample_t) - 1));

  // DUT inputs seen during one clock cycle
  typedef struct packed {
    logic                   rst;
    logic                   loop;
    gen_pair_t [NUM_CH-1:0] gen;
    adc_raw_t  [NUM_CH-1:0] adc;
  } cycle_t;

  logic                     adc_clk;
  logic                     rst_n_i;
  adc_raw_t    [NUM_CH-1:0] adc_dat_i;
  gen_pair_t   [NUM_CH-1:0] gen_i;
  logic                     digital_loop_i;
  acq_sample_t [NUM_CH-1:0] acq_dat_o;
  dac_code_t   [NUM_CH-1:0] dac_dat_o;
  logic                     dac_reset_o;

  logic [31:0] lfsr_state;
  int unsigned clamp_hits;  // clamped sums seen on the DAC
  int unsigned loop_checks;  // acquisition samples from loopback
  cycle_t      hist[$];  // cycles m-2, m-1, m

  analog_frontend #(
    .NUM_CH (NUM_CH)
  ) DUT (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .acq_dat_o      (acq_dat_o),
    .gen_i          (gen_i),
    .digital_loop_i (digital_loop_i),
    .dac_dat_o      (dac_dat_o),
    .dac_reset_o    (dac_reset_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  ////////////////////
  // stimulus source
  ////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic int ref_sum(input gen_pair_t g);
    return int'($signed(g.asg)) + int'($signed(g.pid));
  endfunction

  // saturate to the signed sample range, then invert for the DAC
  function automatic dac_code_t ref_code(input gen_pair_t g);
    int s;
    s = ref_sum(g);
    if (s > GEN_HI) begin
      s = GEN_HI;
    end else if (s < GEN_LO) begin
      s = GEN_LO;
    end
    return ~dac_code_t'(s);
  endfunction

  function automatic acq_sample_t ref_upper(input adc_raw_t w);
    return acq_sample_t'(w >> ACQ_DROP);  // keep the top 12 bits
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic stop_on_error();
    $display("Checks failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_acq(input int ch, input acq_sample_t got, input acq_sample_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: acq_dat_o[%0d] is %h, expected %h", $time, ch, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_code(input int ch, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: dac_dat_o[%0d] is %h, expected %h", $time, ch, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_reset(input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: dac_reset_o is %b, expected %b", $time, got, exp);
      stop_on_error();
    end
  endtask

  ////////////////////
  // compare process
  ////////////////////

  // outputs are stable at the falling edge
  initial begin : compare_proc
    cycle_t      now_c;
    cycle_t      prev1;
    cycle_t      prev2;
    logic        live;
    int          sum_in;
    dac_code_t   exp_code;
    acq_sample_t exp_acq;
    clamp_hits  = 0;
    loop_checks = 0;
    hist.push_back('0);  // cycles before time zero count as reset
    hist.push_back('0);
    forever begin
      @(negedge adc_clk);
      now_c.rst  = rst_n_i;
      now_c.loop = digital_loop_i;
      now_c.gen  = gen_i;
      now_c.adc  = adc_dat_i;
      hist.push_back(now_c);
      if (hist.size() > 3) begin
        void'(hist.pop_front());
      end
      prev2 = hist[0];
      prev1 = hist[1];
      live  = now_c.rst && prev1.rst;  // output registers out of reset
      check_reset(dac_reset_o, !live);
      for (int k = 0; k < NUM_CH; k++) begin
        // DAC pins crossed, 2 cycles
        exp_code = (live && prev2.rst) ? ref_code(prev2.gen[NUM_CH-1-k]) : '0;
        check_code(k, dac_dat_o[k], exp_code);
        if (live && prev2.rst) begin
          sum_in = ref_sum(prev2.gen[NUM_CH-1-k]);
          if (sum_in > GEN_HI || sum_in < GEN_LO) begin
            clamp_hits++;
          end
        end
        if (!live) begin
          exp_acq = '0;
        end else if (prev1.loop) begin
          exp_acq = ref_upper(ref_code(prev1.gen[k]));  // own channel, 1 cycle
          loop_checks++;
        end else if (prev2.rst) begin
          exp_acq = ref_upper(prev2.adc[NUM_CH-1-k]);  // crossed, 2 cycles
        end else begin
          exp_acq = '0;  // input register still in reset
        end
        check_acq(k, acq_dat_o[k], exp_acq);
      end
    end
  end

  ////////////////////
  // stimulus process
  ////////////////////

  initial begin : stim_proc
    logic [31:0] r;
    gen_pair_t   g;
    lfsr_state     = 32'h57f24c5b;
    rst_n_i        = 1'b1;
    digital_loop_i = 1'b0;
    adc_dat_i      = '0;
    gen_i          = '0;
    #(CLK_PERIOD / 4);
    rst_n_i = 1'b0;  // falling edge applies the async reset
    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      for (int k = 0; k < NUM_CH; k++) begin
        draw_bits(3, r);
        if (r[2:0] == 3'd0) begin
          g.asg = gen_sample_t'(GEN_HI);  // positive overflow
          g.pid = gen_sample_t'(GEN_HI);
        end else if (r[2:0] == 3'd1) begin
          g.asg = gen_sample_t'(GEN_LO);  // negative overflow
          g.pid = gen_sample_t'(GEN_LO);
        end else begin
          draw_bits(14, r);
          g.asg = gen_sample_t'(r[13:0]);
          draw_bits(14, r);
          g.pid = gen_sample_t'(r[13:0]);
        end
        gen_i[k] <= g;
        draw_bits(14, r);
        adc_dat_i[k] <= adc_raw_t'(r[13:0]);
      end
      // long loopback windows plus a one cycle pulse
      digital_loop_i <= ((cyc % 64) >= 40) || (cyc == 17);
      @(posedge adc_clk);
    end
    digital_loop_i <= 1'b0;
    repeat (DRAIN_CYCLES) @(posedge adc_clk);
    if (clamp_hits > 0 && loop_checks > 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("clamping or loopback was never exercised");
      stop_on_error();
    end
  end

  // ends a hung run
  initial begin : watchdog_proc
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t before the test finished", $time);
    stop_on_error();
  end

endmodule : tb_analog_frontend

`default_nettype wire

/* verilog.f */
design/afe_pkg.sv
design/adc_capture.sv
design/dac_channel.sv
design/dac_output.sv
design/analog_frontend.sv
verif/analog_frontend_properties.sv
verif/tb_analog_frontend.sv

/* Makefile */
# Verilator build and run of the analog front end testbench
# the exit status of the simulation is the pass or fail result

VERILATOR ?= verilator
TOP       ?= tb_analog_frontend
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
